/* hdl/axi_adapter_pkg.sv */
package axi_adapter_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_DATA_WIDTH = 64;
  localparam int unsigned AXI_ID_WIDTH   = 4;

  typedef logic [AXI_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0]   data_t;
  typedef logic [AXI_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [AXI_ID_WIDTH-1:0]     id_t;
  typedef logic [7:0]                  len_t;
  typedef logic [2:0]                  size_t;
  typedef logic [1:0]                  burst_t;
  typedef logic [1:0]                  resp_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // one word or a whole cache line
  typedef enum logic {
    SINGLE_REQ,
    LINE_REQ
  } req_kind_e;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  // address channel, shared by AW and AR
  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    id_t    id;
  } ax_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // master to slave
  typedef struct packed {
    ax_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ax_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // slave to master
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

endpackage

/* hdl/axi_write_ctrl.sv */
`timescale 1ns/1ps

module axi_write_ctrl #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    start_i,
  input  axi_adapter_pkg::req_kind_e              kind_i,
  input  axi_adapter_pkg::addr_t                  addr_i,
  input  axi_adapter_pkg::size_t                  size_i,
  input  axi_adapter_pkg::id_t                    id_i,
  input  axi_adapter_pkg::data_t [LINE_BEATS-1:0] wdata_i,
  input  axi_adapter_pkg::strb_t [LINE_BEATS-1:0] be_i,
  output axi_adapter_pkg::ax_chan_t               aw_o,
  output logic                                    aw_valid_o,
  input  logic                                    aw_ready_i,
  output axi_adapter_pkg::w_chan_t                w_o,
  output logic                                    w_valid_o,
  input  logic                                    w_ready_i,
  input  axi_adapter_pkg::b_chan_t                b_i,
  input  logic                                    b_valid_i,
  output logic                                    b_ready_o,
  output logic                                    gnt_o,
  output logic                                    valid_o,
  output axi_adapter_pkg::id_t                    id_o,
  output logic                                    busy_o
);
  import axi_adapter_pkg::*;

  localparam int unsigned CNT_W       = $clog2(LINE_BEATS);
  localparam int unsigned LINE_OFFSET = $clog2(LINE_BEATS * AXI_DATA_WIDTH / 8);

  typedef enum logic [2:0] {
    IDLE,
    SEND,
    WAIT_AW,
    WAIT_W,
    WAIT_B
  } state_e;

  state_e           state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             sending;
  logic             last_beat;
  // which of address and data has gone out by the end of this cycle
  logic             aw_done, w_done;

  assign sending   = (state_q == IDLE) ? start_i : (state_q != WAIT_B);
  assign last_beat = (kind_i == SINGLE_REQ) || (cnt_q == CNT_W'(LINE_BEATS - 1));
  assign busy_o    = (state_q != IDLE);

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  always_comb begin
    aw_o.addr  = addr_i;
    aw_o.len   = '0;
    aw_o.size  = size_i;
    aw_o.burst = BURST_INCR;
    aw_o.id    = id_i;
    // line bursts start on the line boundary
    if (kind_i == LINE_REQ) begin
      aw_o.addr[LINE_OFFSET-1:0] = '0;
      aw_o.len                   = len_t'(LINE_BEATS - 1);
    end

    w_o.data = wdata_i[cnt_q];
    w_o.strb = be_i[cnt_q];
    w_o.last = last_beat;
  end

  // ----------------------------------------
  // AW/W/B FSM
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    id_o       = '0;
    aw_done    = 1'b0;
    w_done     = 1'b0;

    if (sending) begin
      aw_valid_o = (state_q != WAIT_W);
      w_valid_o  = (state_q != WAIT_AW);
      aw_done    = (state_q == WAIT_W) || (aw_valid_o && aw_ready_i);
      w_done     = (state_q == WAIT_AW) || (w_valid_o && w_ready_i && last_beat);

      // step to the next beat, wrap to zero after the last one
      if (w_valid_o && w_ready_i) begin
        cnt_d = last_beat ? '0 : cnt_q + 1'b1;
      end

      unique case ({aw_done, w_done})
        2'b11: begin
          gnt_o   = 1'b1;
          state_d = WAIT_B;
        end
        2'b10:   state_d = WAIT_W;
        2'b01:   state_d = WAIT_AW;
        default: state_d = SEND;
      endcase
    end else if (state_q == WAIT_B) begin
      b_ready_o = 1'b1;
      if (b_valid_i) begin
        valid_o = 1'b1;
        id_o    = b_i.id;
        state_d = IDLE;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

/* hdl/axi_read_ctrl.sv */
`timescale 1ns/1ps

module axi_read_ctrl #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    start_i,
  input  axi_adapter_pkg::req_kind_e              kind_i,
  input  axi_adapter_pkg::addr_t                  addr_i,
  input  axi_adapter_pkg::size_t                  size_i,
  input  axi_adapter_pkg::id_t                    id_i,
  output axi_adapter_pkg::ax_chan_t               ar_o,
  output logic                                    ar_valid_o,
  input  logic                                    ar_ready_i,
  input  axi_adapter_pkg::r_chan_t                r_i,
  input  logic                                    r_valid_i,
  output logic                                    r_ready_o,
  output logic                                    gnt_o,
  output logic                                    valid_o,
  output axi_adapter_pkg::id_t                    id_o,
  output axi_adapter_pkg::data_t [LINE_BEATS-1:0] rdata_o,
  output logic                                    busy_o
);
  import axi_adapter_pkg::*;

  localparam int unsigned CNT_W       = $clog2(LINE_BEATS);
  localparam int unsigned LINE_OFFSET = $clog2(LINE_BEATS * AXI_DATA_WIDTH / 8);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_R,
    COMPLETE
  } state_e;

  state_e           state_q, state_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             beat_acc;

  // line buffer and the id of the final beat
  data_t [LINE_BEATS-1:0] line_q;
  id_t                    id_q;

  assign beat_acc = (state_q == WAIT_R) && r_valid_i;
  assign rdata_o  = line_q;
  assign busy_o   = (state_q != IDLE);

  // ----------------------------------------
  // AR payload
  // ----------------------------------------
  always_comb begin
    ar_o.addr  = addr_i;
    ar_o.len   = '0;
    ar_o.size  = size_i;
    ar_o.burst = BURST_INCR;
    ar_o.id    = id_i;
    // incrementing line burst, so start at the line base
    if (kind_i == LINE_REQ) begin
      ar_o.addr[LINE_OFFSET-1:0] = '0;
      ar_o.len                   = len_t'(LINE_BEATS - 1);
    end
  end

  // ----------------------------------------
  // AR/R FSM
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    ar_valid_o = 1'b0;
    r_ready_o  = 1'b0;
    gnt_o      = 1'b0;
    valid_o    = 1'b0;
    id_o       = '0;

    unique case (state_q)
      IDLE: begin
        // valid stays up as long as the client holds its request
        ar_valid_o = start_i;
        if (start_i && ar_ready_i) begin
          gnt_o   = 1'b1;
          state_d = WAIT_R;
        end
      end

      WAIT_R: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          if (r_i.last) begin
            cnt_d   = '0;
            state_d = COMPLETE;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      COMPLETE: begin
        valid_o = 1'b1;
        id_o    = id_q;
        state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // beat k lands in word k, a single read only ever fills word 0
  always_ff @(posedge clk_i) begin
    if (beat_acc) begin
      line_q[cnt_q] <= r_i.data;
    end
    if (beat_acc && r_i.last) begin
      id_q <= r_i.id;
    end
  end

endmodule

/* hdl/axi_adapter.sv */
`timescale 1ns/1ps

module axi_adapter #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // client side
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  axi_adapter_pkg::req_kind_e              kind_i,
  input  axi_adapter_pkg::addr_t                  addr_i,
  input  axi_adapter_pkg::size_t                  size_i,
  input  axi_adapter_pkg::id_t                    id_i,
  input  axi_adapter_pkg::data_t [LINE_BEATS-1:0] wdata_i,
  input  axi_adapter_pkg::strb_t [LINE_BEATS-1:0] be_i,
  output logic                                    gnt_o,
  output logic                                    valid_o,
  output axi_adapter_pkg::id_t                    id_o,
  output axi_adapter_pkg::data_t [LINE_BEATS-1:0] rdata_o,
  output logic                                    busy_o,
  // AXI side
  output axi_adapter_pkg::axi_req_t               axi_req_o,
  input  axi_adapter_pkg::axi_rsp_t               axi_rsp_i
);
  import axi_adapter_pkg::*;

  // write controller outputs
  ax_chan_t wr_aw;
  w_chan_t  wr_w;
  logic     wr_aw_valid, wr_w_valid, wr_b_ready;
  logic     wr_gnt, wr_valid, wr_busy;
  id_t      wr_id;

  // read controller outputs
  ax_chan_t rd_ar;
  logic     rd_ar_valid, rd_r_ready;
  logic     rd_gnt, rd_valid, rd_busy;
  id_t      rd_id;

  logic wr_start, rd_start;

  // a request only starts while the other direction is idle
  assign wr_start = req_i && we_i && !rd_busy;
  assign rd_start = req_i && !we_i && !wr_busy;

  axi_write_ctrl #(
    .LINE_BEATS (LINE_BEATS)
  ) axi_write_ctrl_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (wr_start),
    .kind_i     (kind_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .aw_o       (wr_aw),
    .aw_valid_o (wr_aw_valid),
    .aw_ready_i (axi_rsp_i.aw_ready),
    .w_o        (wr_w),
    .w_valid_o  (wr_w_valid),
    .w_ready_i  (axi_rsp_i.w_ready),
    .b_i        (axi_rsp_i.b),
    .b_valid_i  (axi_rsp_i.b_valid),
    .b_ready_o  (wr_b_ready),
    .gnt_o      (wr_gnt),
    .valid_o    (wr_valid),
    .id_o       (wr_id),
    .busy_o     (wr_busy)
  );

  axi_read_ctrl #(
    .LINE_BEATS (LINE_BEATS)
  ) axi_read_ctrl_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (rd_start),
    .kind_i     (kind_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .ar_o       (rd_ar),
    .ar_valid_o (rd_ar_valid),
    .ar_ready_i (axi_rsp_i.ar_ready),
    .r_i        (axi_rsp_i.r),
    .r_valid_i  (axi_rsp_i.r_valid),
    .r_ready_o  (rd_r_ready),
    .gnt_o      (rd_gnt),
    .valid_o    (rd_valid),
    .id_o       (rd_id),
    .rdata_o    (rdata_o),
    .busy_o     (rd_busy)
  );

  // ----------------------------------------
  // AXI request assembly
  // ----------------------------------------
  always_comb begin
    axi_req_o.aw       = wr_aw;
    axi_req_o.aw_valid = wr_aw_valid;
    axi_req_o.w        = wr_w;
    axi_req_o.w_valid  = wr_w_valid;
    axi_req_o.b_ready  = wr_b_ready;
    axi_req_o.ar       = rd_ar;
    axi_req_o.ar_valid = rd_ar_valid;
    axi_req_o.r_ready  = rd_r_ready;
  end

  // only one controller is active, idle ones drive zero
  assign gnt_o   = wr_gnt | rd_gnt;
  assign valid_o = wr_valid | rd_valid;
  assign id_o    = wr_id | rd_id;
  assign busy_o  = wr_busy | rd_busy;

endmodule

/* verification/axi_adapter_checker.sv */
`timescale 1ns/1ps

module axi_adapter_checker #(
  parameter int unsigned LINE_BEATS = 4
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  axi_adapter_pkg::req_kind_e              kind_i,
  input  axi_adapter_pkg::size_t                  size_i,
  input  axi_adapter_pkg::id_t                    id_i,
  input  axi_adapter_pkg::data_t [LINE_BEATS-1:0] wdata_i,
  input  axi_adapter_pkg::strb_t [LINE_BEATS-1:0] be_i,
  input  axi_adapter_pkg::addr_t                  exp_ax_addr_i,
  input  logic                                    gnt_i,
  input  logic                                    valid_i,
  input  axi_adapter_pkg::id_t                    rsp_id_i,
  input  axi_adapter_pkg::data_t [LINE_BEATS-1:0] rdata_i,
  input  logic                                    busy_i,
  input  axi_adapter_pkg::axi_req_t               axi_req_i,
  input  axi_adapter_pkg::axi_rsp_t               axi_rsp_i,
  output int                                      value_errs_o,
  output int                                      other_errs_o,
  output int                                      grants_o
);
  import axi_adapter_pkg::*;

  localparam int unsigned IDX_W = $clog2(LINE_BEATS);

  // reference memory keyed by 8-byte word index
  data_t       ref_mem [addr_t];
  int          value_errs = 0;
  int          other_errs = 0;
  int          grants     = 0;
  logic        seen_req   = 1'b0;
  logic        pending    = 1'b0;
  logic        pend_we;
  req_kind_e   pend_kind;
  addr_t       pend_addr;
  id_t         pend_id;
  int unsigned w_beats    = 0;

  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs;
  assign grants_o     = grants;

  function automatic data_t ref_word(addr_t widx);
    if (ref_mem.exists(widx)) begin
      return ref_mem[widx];
    end
    return {~widx, widx};
  endfunction

  function automatic data_t apply_strobes(data_t old_w, data_t new_w, strb_t strb);
    data_t mask;
    mask = {{8{strb[7]}}, {8{strb[6]}}, {8{strb[5]}}, {8{strb[4]}},
            {8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic int unsigned beats_of(req_kind_e kind);
    return (kind == LINE_REQ) ? LINE_BEATS : 1;
  endfunction

  task automatic check_val(string name, data_t got, data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      value_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    addr_t widx;
    // quiet outputs from reset until the client asks for something
    if (req_i) begin
      seen_req = 1'b1;
    end else if (rst_n_i && !seen_req && (gnt_i || valid_i || busy_i ||
        axi_req_i.aw_valid || axi_req_i.w_valid || axi_req_i.ar_valid ||
        axi_req_i.b_ready || axi_req_i.r_ready)) begin
      $display("DUT output active before the first request");
      other_errs++;
    end

    // ----------------------------------------
    // address and data channels
    // ----------------------------------------
    if (axi_req_i.aw_valid && axi_rsp_i.aw_ready) begin
      check_val("aw.addr", data_t'(axi_req_i.aw.addr), data_t'(exp_ax_addr_i));
      check_val("aw.len", data_t'(axi_req_i.aw.len), data_t'(beats_of(kind_i) - 1));
      check_val("aw.size", data_t'(axi_req_i.aw.size), data_t'(size_i));
      check_val("aw.id", data_t'(axi_req_i.aw.id), data_t'(id_i));
      // line bursts step through consecutive words
      if (kind_i == LINE_REQ) begin
        check_val("aw.burst", data_t'(axi_req_i.aw.burst), data_t'(BURST_INCR));
      end
    end
    if (axi_req_i.ar_valid && axi_rsp_i.ar_ready) begin
      check_val("ar.addr", data_t'(axi_req_i.ar.addr), data_t'(exp_ax_addr_i));
      check_val("ar.len", data_t'(axi_req_i.ar.len), data_t'(beats_of(kind_i) - 1));
      check_val("ar.size", data_t'(axi_req_i.ar.size), data_t'(size_i));
      check_val("ar.id", data_t'(axi_req_i.ar.id), data_t'(id_i));
      if (kind_i == LINE_REQ) begin
        check_val("ar.burst", data_t'(axi_req_i.ar.burst), data_t'(BURST_INCR));
      end
    end
    if (axi_req_i.w_valid && axi_rsp_i.w_ready) begin
      w_beats++;
      check_val("w.last", data_t'(axi_req_i.w.last), data_t'(w_beats == beats_of(kind_i)));
      if (w_beats <= LINE_BEATS) begin
        check_val("w.data", axi_req_i.w.data, wdata_i[IDX_W'(w_beats - 1)]);
        check_val("w.strb", data_t'(axi_req_i.w.strb), data_t'(be_i[IDX_W'(w_beats - 1)]));
      end
    end

    // ----------------------------------------
    // client responses
    // ----------------------------------------
    if (valid_i) begin
      if (!pending) begin
        $display("valid_o pulsed with no granted request open");
        other_errs++;
      end else begin
        check_val("id_o", data_t'(rsp_id_i), data_t'(pend_id));
        if (!pend_we) begin
          for (int unsigned k = 0; k < beats_of(pend_kind); k++) begin
            check_val($sformatf("rdata_o[%0d]", k), rdata_i[IDX_W'(k)],
                      ref_word(pend_addr / 8 + addr_t'(k)));
          end
        end
      end
      pending = 1'b0;
    end

    if (gnt_i) begin
      if (pending) begin
        $display("gnt_o pulsed while the previous request had no valid_o yet");
        other_errs++;
      end
      if (we_i) begin
        check_val("w beat count", data_t'(w_beats), data_t'(beats_of(kind_i)));
        for (int unsigned k = 0; k < beats_of(kind_i); k++) begin
          widx          = exp_ax_addr_i / 8 + addr_t'(k);
          ref_mem[widx] = apply_strobes(ref_word(widx), wdata_i[IDX_W'(k)], be_i[IDX_W'(k)]);
        end
      end
      w_beats   = 0;
      pending   = 1'b1;
      pend_we   = we_i;
      pend_kind = kind_i;
      pend_addr = exp_ax_addr_i;
      pend_id   = id_i;
      grants++;
    end
  end

endmodule

/* verification/tb_axi_adapter.sv */
`timescale 1ns/1ps

module tb_axi_adapter;
  import axi_adapter_pkg::*;

  localparam int unsigned LINE_BEATS = 4;
  localparam int unsigned IDX_W      = $clog2(LINE_BEATS);
  localparam int unsigned TIMEOUT    = 200;

  typedef struct packed {
    logic                   we;
    req_kind_e              kind;
    addr_t                  addr;
    addr_t                  ax_addr;  // expected AW/AR address
    id_t                    id;
    logic                   slow;     // slave stalls its handshakes
    data_t [LINE_BEATS-1:0] data;
    strb_t [LINE_BEATS-1:0] strb;
  } stim_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req, we, gnt, valid, busy, slow;
  req_kind_e              kind;
  addr_t                  addr, exp_ax_addr;
  size_t                  size;
  id_t                    id, rsp_id;
  data_t [LINE_BEATS-1:0] wdata, rdata;
  strb_t [LINE_BEATS-1:0] be;
  axi_req_t               axi_req;
  axi_rsp_t               axi_rsp;
  int                     value_errs, other_errs, grants;
  stim_t                  stim_q[$];

  // slave model state, memory keyed by 8-byte word index
  data_t       mem [addr_t];
  ax_chan_t    aw_q    = '0;
  ax_chan_t    ar_q    = '0;
  logic        aw_have = 1'b0;
  logic        w_end   = 1'b0;
  logic        b_pend  = 1'b0;
  logic        r_busy  = 1'b0;
  data_t       w_data_q[$];
  strb_t       w_strb_q[$];
  int unsigned aw_dly = 0;
  int unsigned w_dly  = 0;
  int unsigned b_dly  = 0;
  int unsigned ar_dly = 0;
  int unsigned r_dly  = 0;
  int unsigned r_beat = 0;

  always #50 clk = ~clk;

  axi_adapter #(
    .LINE_BEATS (LINE_BEATS)
  ) axi_adapter_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .req_i     (req),
    .we_i      (we),
    .kind_i    (kind),
    .addr_i    (addr),
    .size_i    (size),
    .id_i      (id),
    .wdata_i   (wdata),
    .be_i      (be),
    .gnt_o     (gnt),
    .valid_o   (valid),
    .id_o      (rsp_id),
    .rdata_o   (rdata),
    .busy_o    (busy),
    .axi_req_o (axi_req),
    .axi_rsp_i (axi_rsp)
  );

  axi_adapter_checker #(
    .LINE_BEATS (LINE_BEATS)
  ) axi_adapter_checker_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_i         (req),
    .we_i          (we),
    .kind_i        (kind),
    .size_i        (size),
    .id_i          (id),
    .wdata_i       (wdata),
    .be_i          (be),
    .exp_ax_addr_i (exp_ax_addr),
    .gnt_i         (gnt),
    .valid_i       (valid),
    .rsp_id_i      (rsp_id),
    .rdata_i       (rdata),
    .busy_i        (busy),
    .axi_req_i     (axi_req),
    .axi_rsp_i     (axi_rsp),
    .value_errs_o  (value_errs),
    .other_errs_o  (other_errs),
    .grants_o      (grants)
  );

  function automatic data_t mem_word(addr_t widx);
    if (mem.exists(widx)) begin
      return mem[widx];
    end
    return {~widx, widx};
  endfunction

  function automatic data_t masked_write(data_t old_w, data_t new_w, strb_t strb);
    data_t mask;
    mask = {{8{strb[7]}}, {8{strb[6]}}, {8{strb[5]}}, {8{strb[4]}},
            {8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic int unsigned new_delay();
    return slow ? $urandom % 4 : 0;
  endfunction

  // ----------------------------------------
  // AXI slave memory model
  // ----------------------------------------
  // handshakes are sampled on the rising edge
  initial begin
    addr_t widx;
    void'($urandom(32'hbafa));
    forever begin
      @(posedge clk);
      if (axi_req.aw_valid && axi_rsp.aw_ready) begin
        aw_q    = axi_req.aw;
        aw_have = 1'b1;
        aw_dly  = new_delay();
      end else if (aw_dly != 0) begin
        aw_dly--;
      end
      if (axi_req.w_valid && axi_rsp.w_ready) begin
        w_data_q.push_back(axi_req.w.data);
        w_strb_q.push_back(axi_req.w.strb);
        w_end = axi_req.w.last;
        w_dly = new_delay();
      end else if (w_dly != 0) begin
        w_dly--;
      end
      if (axi_rsp.b_valid && axi_req.b_ready) begin
        b_pend = 1'b0;
      end else if (b_dly != 0) begin
        b_dly--;
      end
      // store the burst once address and last beat are both in
      if (aw_have && w_end) begin
        widx = aw_q.addr / 8;
        while (w_data_q.size() > 0) begin
          mem[widx] = masked_write(mem_word(widx), w_data_q.pop_front(), w_strb_q.pop_front());
          widx++;
        end
        aw_have = 1'b0;
        w_end   = 1'b0;
        b_pend  = 1'b1;
        b_dly   = new_delay();
      end
      if (axi_rsp.r_valid && axi_req.r_ready) begin
        r_busy = !axi_rsp.r.last;
        r_beat++;
        r_dly  = new_delay();
      end else if (r_dly != 0) begin
        r_dly--;
      end
      if (axi_req.ar_valid && axi_rsp.ar_ready) begin
        ar_q   = axi_req.ar;
        r_busy = 1'b1;
        r_beat = 0;
        r_dly  = new_delay();
        ar_dly = new_delay();
      end else if (ar_dly != 0) begin
        ar_dly--;
      end
    end
  end

  // responses change on the falling edge only
  initial begin
    axi_rsp = '0;
    forever begin
      @(negedge clk);
      axi_rsp.aw_ready = (aw_dly == 0) && !aw_have && !b_pend;
      axi_rsp.w_ready  = (w_dly == 0) && !w_end && !b_pend;
      axi_rsp.b_valid  = b_pend && (b_dly == 0);
      axi_rsp.b.id     = aw_q.id;
      axi_rsp.b.resp   = RESP_OKAY;
      axi_rsp.ar_ready = (ar_dly == 0) && !r_busy;
      axi_rsp.r_valid  = r_busy && (r_dly == 0);
      axi_rsp.r.data   = mem_word(ar_q.addr / 8 + r_beat);
      axi_rsp.r.id     = ar_q.id;
      axi_rsp.r.resp   = RESP_OKAY;
      axi_rsp.r.last   = (r_beat == 32'(ar_q.len));
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic add_entry(input logic we_v, input req_kind_e kind_v, input addr_t addr_v,
                           input addr_t ax_v, input id_t id_v, input logic slow_v,
                           input data_t seed_v, input logic [31:0] strb_v);
    stim_t s;
    s.we      = we_v;
    s.kind    = kind_v;
    s.addr    = addr_v;
    s.ax_addr = ax_v;
    s.id      = id_v;
    s.slow    = slow_v;
    for (int k = 0; k < LINE_BEATS; k++) begin
      s.data[IDX_W'(k)] = seed_v + data_t'(k) * 64'h0101_0101_0101_0101;
      s.strb[IDX_W'(k)] = strb_v[8*k +: 8];
    end
    stim_q.push_back(s);
  endtask

  task automatic wait_for_pulse(input bit on_valid, output bit seen);
    int unsigned n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      seen = on_valid ? valid : gnt;
      n++;
    end
    if (!seen) begin
      $display("timeout: no %s pulse within %0d cycles", on_valid ? "valid_o" : "gnt_o", TIMEOUT);
    end
  endtask

  initial begin
    stim_t s;
    bit    ok;
    bit    timed_out;
    int    run_errs;
    rst_n       = 1'b0;
    req         = 1'b0;
    we          = 1'b0;
    kind        = SINGLE_REQ;
    addr        = '0;
    size        = 3'd3;
    id          = '0;
    wdata       = '0;
    be          = '0;
    exp_ax_addr = '0;
    slow        = 1'b0;
    timed_out   = 1'b0;
    run_errs    = 0;

    // we, kind, addr, expected ax addr, id, slow, data seed, strobes
    add_entry(1'b1, LINE_REQ,   32'h1008, 32'h1000, 4'h1, 1'b0, 64'h1111_2222_3333_4444, 32'hffff_ffff);
    add_entry(1'b0, LINE_REQ,   32'h1010, 32'h1000, 4'h2, 1'b0, '0, '0);
    add_entry(1'b1, SINGLE_REQ, 32'h1010, 32'h1010, 4'h3, 1'b1, 64'hdead_beef_cafe_f00d, 32'h0000_000f);
    add_entry(1'b0, SINGLE_REQ, 32'h1010, 32'h1010, 4'h4, 1'b1, '0, '0);
    add_entry(1'b1, SINGLE_REQ, 32'h2000, 32'h2000, 4'h5, 1'b1, 64'h0123_4567_89ab_cdef, 32'h0000_00f0);
    add_entry(1'b0, SINGLE_REQ, 32'h2000, 32'h2000, 4'h6, 1'b0, '0, '0);
    add_entry(1'b1, LINE_REQ,   32'h2018, 32'h2000, 4'h7, 1'b1, 64'h5555_aaaa_0f0f_f0f0, 32'h813c_00ff);
    add_entry(1'b0, LINE_REQ,   32'h2004, 32'h2000, 4'h8, 1'b1, '0, '0);
    add_entry(1'b0, LINE_REQ,   32'h1000, 32'h1000, 4'h9, 1'b1, '0, '0);
    add_entry(1'b0, SINGLE_REQ, 32'h2008, 32'h2008, 4'ha, 1'b0, '0, '0);

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
      s = stim_q[i];
      @(negedge clk);
      slow        = s.slow;
      req         = 1'b1;
      we          = s.we;
      kind        = s.kind;
      addr        = s.addr;
      id          = s.id;
      wdata       = s.data;
      be          = s.strb;
      exp_ax_addr = s.ax_addr;
      wait_for_pulse(1'b0, ok);
      if (ok) begin
        @(negedge clk);
        req = 1'b0;
        wait_for_pulse(1'b1, ok);
      end
      timed_out = !ok;
    end

    repeat (4) @(negedge clk);
    if (!timed_out && grants != stim_q.size()) begin
      $display("%0d grants seen for %0d requests", grants, stim_q.size());
      run_errs++;
    end
    $display("errors: %0d value, %0d protocol, %0d run, %0d timeout",
             value_errs, other_errs, run_errs, timed_out);
    if (value_errs == 0 && other_errs == 0 && run_errs == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/axi_adapter_pkg.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/axi_adapter.sv
verification/axi_adapter_checker.sv
verification/tb_axi_adapter.sv

/* Makefile */
# Verilator build of the AXI adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_adapter
FILELIST  ?= project.f
BUILD     ?= build
LOG       ?= $(BUILD)/sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@grep -q "Verification passed" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD)
